/* sources.f */
logic/alu_ops_pkg.sv
logic/packet_fifo.sv
logic/alu_ops_control.sv
logic/alu_ops_kernel.sv
logic/credit_tx_port.sv
logic/alu_ops_engine.sv
testbench/alu_ops_engine_sva.sv
testbench/alu_ops_engine_tb.sv

/* testbench/alu_ops_engine_tb.sv */
// Directed testbench for the ALU-operation engine: reset, operations, job control and credits.
// Compile with sources.f and run alu_ops_engine_tb as the top module.
`timescale 1ns/1ns

module alu_ops_engine_tb;
    import alu_ops_pkg::*;

    localparam int IN_FIFO_DEPTH  = DEFAULT_FIFO_DEPTH;
    localparam int OUT_CREDITS    = DEFAULT_OUT_CREDITS;
    localparam int TIMEOUT_CYCLES = 3000;

    typedef struct packed {
        route_t route_from;
        route_t route_to;
        addr_t  addr;
        data_t  data;
    } pkt_t;

    logic    ap_clk;
    logic    areset_generator;
    logic    descriptor_valid;
    count_t  descriptor_count;
    logic    config_valid;
    alu_op_t config_op;
    data_t   config_operand;
    logic    in_valid;
    route_t  in_route_from;
    route_t  in_route_to;
    addr_t   in_addr;
    data_t   in_data;
    logic    in_credit;
    logic    out_valid;
    route_t  out_route_from;
    route_t  out_route_to;
    addr_t   out_addr;
    data_t   out_data;
    logic    out_credit;
    logic    busy;
    logic    done;

    logic    auto_credit;
    logic    manual_credit;
    logic    credit_return_en;

    integer  seed;
    int      cycle_count = 0;
    int      checks = 0;
    int      value_errors = 0;
    int      other_errors = 0;

    // Reference model state
    pkt_t    pending_q[$];
    pkt_t    expect_q[$];
    int      job_left = 0;
    alu_op_t job_op = ALU_PASS;
    data_t   job_operand = '0;
    count_t  next_job_count = '0;
    int      jobs_started = 0;
    int      packets_sent = 0;
    int      in_credit_seen = 0;
    int      out_seen = 0;
    int      done_count = 0;

    assign out_credit = auto_credit | manual_credit;

    alu_ops_engine u_alu_ops_engine (.*);

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Compare tasks and reporting
    // ------------------------------------------------------------------
    task automatic compare_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_route(input string name, input route_t got, input route_t exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic data_t expected_result(alu_op_t code, data_t a, data_t b);
        case (code)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            default: return a;
        endcase
    endfunction

    // The active job takes packets in arrival order until its count runs out
    function automatic void assign_pending();
        pkt_t p;
        while (job_left > 0 && pending_q.size() > 0) begin
            p = pending_q.pop_front();
            p.data = expected_result(job_op, p.data, job_operand);
            expect_q.push_back(p);
            job_left--;
        end
    endfunction

    // Output checker and automatic credit return
    always @(negedge ap_clk) begin
        pkt_t p;
        auto_credit <= out_valid & credit_return_en;
        if (in_credit === 1'b1) begin
            in_credit_seen++;
        end
        if (done === 1'b1) begin
            done_count++;
        end
        if (out_valid === 1'b1) begin
            out_seen++;
            if (expect_q.size() == 0) begin
                report_failure("an output packet arrived with none expected");
            end else begin
                p = expect_q.pop_front();
                compare_route("out_route_from", out_route_from, p.route_from);
                compare_route("out_route_to", out_route_to, p.route_to);
                compare_addr("out_addr", out_addr, p.addr);
                compare_data("out_data", out_data, p.data);
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus helpers, all entered and left just after a falling edge
    // ------------------------------------------------------------------
    task automatic send_packet();
        pkt_t p;
        // Stay within the input credits
        while (packets_sent - in_credit_seen >= IN_FIFO_DEPTH) begin
            @(negedge ap_clk);
        end
        p.route_from = route_t'($random(seed));
        p.route_to = route_t'($random(seed));
        p.addr = addr_t'($random(seed));
        p.data = data_t'($random(seed));
        in_valid = 1'b1;
        in_route_from = p.route_from;
        in_route_to = p.route_to;
        in_addr = p.addr;
        in_data = p.data;
        pending_q.push_back(p);
        packets_sent++;
        assign_pending();
        @(negedge ap_clk);
        in_valid = 1'b0;
    endtask

    task automatic start_job(input count_t n);
        descriptor_valid = 1'b1;
        descriptor_count = n;
        next_job_count = n;
        jobs_started++;
        @(negedge ap_clk);
        descriptor_valid = 1'b0;
        compare_bit("busy", busy, 1'b1);
    endtask

    task automatic pulse_config(input alu_op_t code, input data_t value);
        config_valid = 1'b1;
        config_op = code;
        config_operand = value;
        @(negedge ap_clk);
        config_valid = 1'b0;
    endtask

    task automatic configure_job(input alu_op_t code, input data_t value);
        pulse_config(code, value);
        job_left = next_job_count;
        job_op = code;
        job_operand = value;
        assign_pending();
    endtask

    task automatic return_credit();
        manual_credit = 1'b1;
        @(negedge ap_clk);
        manual_credit = 1'b0;
    endtask

    task automatic finish_job();
        int n;
        n = 0;
        while (done_count < jobs_started) begin
            @(negedge ap_clk);
        end
        while (expect_q.size() > 0 && n < 100) begin
            @(negedge ap_clk);
            n++;
        end
        if (expect_q.size() > 0) begin
            report_failure($sformatf("%0d expected packets never came out", expect_q.size()));
        end
        repeat (4) @(negedge ap_clk);
        if (done_count != jobs_started) begin
            report_failure($sformatf("done pulsed %0d times for %0d jobs",
                                     done_count, jobs_started));
        end
    endtask

    task automatic check_idle_outputs();
        compare_bit("out_valid", out_valid, 1'b0);
        compare_bit("in_credit", in_credit, 1'b0);
        compare_bit("busy", busy, 1'b0);
        compare_bit("done", done, 1'b0);
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic test_reset();
        areset_generator = 1'b1;
        repeat (5) begin
            @(negedge ap_clk);
            check_idle_outputs();
        end
        areset_generator = 1'b0;
        repeat (4) begin
            @(negedge ap_clk);
            check_idle_outputs();
        end
    endtask

    task automatic test_operations();
        alu_op_t ops[6];
        data_t   value;
        ops = '{ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
        foreach (ops[k]) begin
            value = data_t'($random(seed));
            start_job(count_t'(6));
            configure_job(ops[k], value);
            repeat (6) send_packet();
            finish_job();
        end
    endtask

    task automatic test_job_control();
        int before_out;
        // Configuration while idle is dropped
        pulse_config(ALU_ADD, 32'h0000_0001);
        compare_bit("busy", busy, 1'b0);
        start_job(count_t'(3));
        repeat (3) send_packet();
        before_out = out_seen;
        repeat (10) @(negedge ap_clk);
        compare_bit("busy", busy, 1'b1);
        if (out_seen != before_out) begin
            report_failure("packets left the engine before the job was configured");
        end
        configure_job(ALU_XOR, data_t'($random(seed)));
        finish_job();

        // Count of 4 with 6 packets, the last two wait for the next job
        start_job(count_t'(4));
        configure_job(ALU_SUB, data_t'($random(seed)));
        repeat (6) send_packet();
        finish_job();
        before_out = out_seen;
        repeat (10) @(negedge ap_clk);
        compare_bit("busy", busy, 1'b0);
        if (out_seen != before_out) begin
            report_failure("packets beyond the job count were sent out");
        end
        start_job(count_t'(2));
        configure_job(ALU_OR, data_t'($random(seed)));
        finish_job();
    endtask

    task automatic test_output_credits();
        int before_out;
        int k;
        credit_return_en = 1'b0;
        before_out = out_seen;
        start_job(count_t'(8));
        configure_job(ALU_ADD, data_t'($random(seed)));
        repeat (8) send_packet();
        while (done_count < jobs_started) begin
            @(negedge ap_clk);
        end
        repeat (20) @(negedge ap_clk);
        if (out_seen - before_out != OUT_CREDITS) begin
            report_failure($sformatf("%0d packets sent without credit return, %0d allowed",
                                     out_seen - before_out, OUT_CREDITS));
        end
        for (k = 0; k < 8 - OUT_CREDITS; k++) begin
            before_out = out_seen;
            return_credit();
            repeat (6) @(negedge ap_clk);
            if (out_seen - before_out != 1) begin
                report_failure($sformatf("one returned credit released %0d packets",
                                         out_seen - before_out));
            end
        end
        if (expect_q.size() != 0) begin
            report_failure("packets were lost under output back-pressure");
        end
        // Give back the credits still held downstream
        repeat (OUT_CREDITS) return_credit();
        credit_return_en = 1'b1;
        finish_job();
    endtask

    task automatic test_input_credits();
        int before_credit;
        int before_out;
        before_credit = in_credit_seen;
        before_out = out_seen;
        repeat (5) send_packet();
        repeat (10) @(negedge ap_clk);
        compare_bit("busy", busy, 1'b0);
        if (in_credit_seen != before_credit) begin
            report_failure("in_credit pulsed with no job active");
        end
        start_job(count_t'(5));
        configure_job(ALU_AND, data_t'($random(seed)));
        finish_job();
        if (in_credit_seen - before_credit != 5 || out_seen - before_out != 5) begin
            report_failure($sformatf("%0d input credits and %0d outputs for a job of 5",
                                     in_credit_seen - before_credit, out_seen - before_out));
        end
    endtask

    initial begin
        int assert_failures;
        seed = 32'he4c5c62e;
        areset_generator = 1'b1;
        descriptor_valid = 1'b0;
        descriptor_count = '0;
        config_valid = 1'b0;
        config_op = ALU_PASS;
        config_operand = '0;
        in_valid = 1'b0;
        in_route_from = '0;
        in_route_to = '0;
        in_addr = '0;
        in_data = '0;
        auto_credit = 1'b0;
        manual_credit = 1'b0;
        credit_return_en = 1'b1;

        test_reset();
        test_operations();
        test_job_control();
        test_output_credits();
        test_input_credits();

        if (in_credit_seen != out_seen) begin
            report_failure("total input credits differ from total output packets");
        end
        assert_failures = u_alu_ops_engine.u_sva.assert_failures;
        $display("Checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checks, value_errors, other_errors, assert_failures);
        if (value_errors == 0 && other_errors == 0 && assert_failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/alu_ops_engine_sva.sv */
// Concurrent checks on output credits, input FIFO writes, done and issue.
// Bound into alu_ops_engine by the bind statement at the end of this file.
`timescale 1ns/1ns

module alu_ops_engine_sva (
    input logic ap_clk,
    input logic areset_generator,
    input logic out_valid,
    input logic credit_zero,
    input logic in_valid,
    input logic in_fifo_full,
    input logic done,
    input logic issue,
    input logic out_fifo_full
);

    int assert_failures = 0;

    // A send always holds a credit
    a_credit: assert property (@(posedge ap_clk) disable iff (areset_generator)
        out_valid |-> !credit_zero)
        else begin
            assert_failures++;
            $error("out_valid with zero output credits");
        end

    a_in_full: assert property (@(posedge ap_clk) disable iff (areset_generator)
        in_valid |-> !in_fifo_full)
        else begin
            assert_failures++;
            $error("input FIFO written while full");
        end

    a_done_pulse: assert property (@(posedge ap_clk) disable iff (areset_generator)
        done |=> !done)
        else begin
            assert_failures++;
            $error("done high for two cycles");
        end

    // The almost-full margin must leave room for the packet in the kernel
    a_issue_room: assert property (@(posedge ap_clk) disable iff (areset_generator)
        issue |=> !out_fifo_full)
        else begin
            assert_failures++;
            $error("issued packet found the output FIFO full");
        end

endmodule

bind alu_ops_engine alu_ops_engine_sva u_sva (
    .ap_clk           (ap_clk),
    .areset_generator (areset_generator),
    .out_valid        (out_valid),
    .credit_zero      (u_credit_tx.credit_count == '0),
    .in_valid         (in_valid),
    .in_fifo_full     (in_fifo_full),
    .done             (done),
    .issue            (issue),
    .out_fifo_full    (u_out_fifo.full)
);

/* logic/alu_ops_engine.sv */
// Top level of the ALU-operation stage: input FIFO, controller, kernel, output
// FIFO and credit port. in_credit returns one credit per packet taken from the input FIFO.
`timescale 1ns/1ns

module alu_ops_engine #(
    parameter int IN_FIFO_DEPTH      = alu_ops_pkg::DEFAULT_FIFO_DEPTH,
    parameter int OUT_FIFO_DEPTH     = alu_ops_pkg::DEFAULT_FIFO_DEPTH,
    parameter int ALMOST_FULL_MARGIN = 2,
    parameter int OUT_CREDITS        = alu_ops_pkg::DEFAULT_OUT_CREDITS
) (
    input  logic                 ap_clk,
    input  logic                 areset_generator,
    input  logic                 descriptor_valid,
    input  alu_ops_pkg::count_t  descriptor_count,
    input  logic                 config_valid,
    input  alu_ops_pkg::alu_op_t config_op,
    input  alu_ops_pkg::data_t   config_operand,
    input  logic                 in_valid,
    input  alu_ops_pkg::route_t  in_route_from,
    input  alu_ops_pkg::route_t  in_route_to,
    input  alu_ops_pkg::addr_t   in_addr,
    input  alu_ops_pkg::data_t   in_data,
    output logic                 in_credit,
    output logic                 out_valid,
    output alu_ops_pkg::route_t  out_route_from,
    output alu_ops_pkg::route_t  out_route_to,
    output alu_ops_pkg::addr_t   out_addr,
    output alu_ops_pkg::data_t   out_data,
    input  logic                 out_credit,
    output logic                 busy,
    output logic                 done
);
    import alu_ops_pkg::*;

    // ------------------------------------------------------------------
    // Pipeline wires
    // ------------------------------------------------------------------
    route_t  head_route_from;
    route_t  head_route_to;
    addr_t   head_addr;
    data_t   head_data;
    logic    in_fifo_empty;
    logic    in_fifo_full;

    logic    issue;
    alu_op_t op;
    data_t   operand;

    logic    res_valid;
    route_t  res_route_from;
    route_t  res_route_to;
    addr_t   res_addr;
    data_t   res_data;

    route_t  tx_route_from;
    route_t  tx_route_to;
    addr_t   tx_addr;
    data_t   tx_data;
    logic    out_fifo_empty;
    logic    out_fifo_almost_full;
    logic    out_fifo_pop;

    // One credit back per issued packet
    assign in_credit = issue;

    packet_fifo #(
        .DEPTH              (IN_FIFO_DEPTH),
        .ALMOST_FULL_MARGIN (ALMOST_FULL_MARGIN)
    ) u_in_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (in_valid),
        .wr_route_from    (in_route_from),
        .wr_route_to      (in_route_to),
        .wr_addr          (in_addr),
        .wr_data          (in_data),
        .rd_en            (issue),
        .rd_route_from    (head_route_from),
        .rd_route_to      (head_route_to),
        .rd_addr          (head_addr),
        .rd_data          (head_data),
        .empty            (in_fifo_empty),
        .full             (in_fifo_full),
        .almost_full      ()
    );

    alu_ops_control u_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor_valid (descriptor_valid),
        .descriptor_count (descriptor_count),
        .config_valid     (config_valid),
        .config_op        (config_op),
        .config_operand   (config_operand),
        .in_empty         (in_fifo_empty),
        .out_almost_full  (out_fifo_almost_full),
        .issue            (issue),
        .op               (op),
        .operand          (operand),
        .busy             (busy),
        .done             (done)
    );

    alu_ops_kernel u_kernel (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .issue            (issue),
        .op               (op),
        .operand          (operand),
        .in_route_from    (head_route_from),
        .in_route_to      (head_route_to),
        .in_addr          (head_addr),
        .in_data          (head_data),
        .res_valid        (res_valid),
        .res_route_from   (res_route_from),
        .res_route_to     (res_route_to),
        .res_addr         (res_addr),
        .res_data         (res_data)
    );

    packet_fifo #(
        .DEPTH              (OUT_FIFO_DEPTH),
        .ALMOST_FULL_MARGIN (ALMOST_FULL_MARGIN)
    ) u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (res_valid),
        .wr_route_from    (res_route_from),
        .wr_route_to      (res_route_to),
        .wr_addr          (res_addr),
        .wr_data          (res_data),
        .rd_en            (out_fifo_pop),
        .rd_route_from    (tx_route_from),
        .rd_route_to      (tx_route_to),
        .rd_addr          (tx_addr),
        .rd_data          (tx_data),
        .empty            (out_fifo_empty),
        .full             (),
        .almost_full      (out_fifo_almost_full)
    );

    credit_tx_port #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_credit_tx (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .fifo_empty       (out_fifo_empty),
        .fifo_route_from  (tx_route_from),
        .fifo_route_to    (tx_route_to),
        .fifo_addr        (tx_addr),
        .fifo_data        (tx_data),
        .out_credit       (out_credit),
        .fifo_pop         (out_fifo_pop),
        .out_valid        (out_valid),
        .out_route_from   (out_route_from),
        .out_route_to     (out_route_to),
        .out_addr         (out_addr),
        .out_data         (out_data)
    );

endmodule

/* logic/credit_tx_port.sv */
// Credit-based transmit port: pops the output FIFO while credits remain and
// presents each packet on out_valid one cycle after the pop.
`timescale 1ns/1ns

module credit_tx_port #(
    parameter int OUT_CREDITS = alu_ops_pkg::DEFAULT_OUT_CREDITS
) (
    input  logic                ap_clk,
    input  logic                areset_generator,
    input  logic                fifo_empty,
    input  alu_ops_pkg::route_t fifo_route_from,
    input  alu_ops_pkg::route_t fifo_route_to,
    input  alu_ops_pkg::addr_t  fifo_addr,
    input  alu_ops_pkg::data_t  fifo_data,
    input  logic                out_credit,
    output logic                fifo_pop,
    output logic                out_valid,
    output alu_ops_pkg::route_t out_route_from,
    output alu_ops_pkg::route_t out_route_to,
    output alu_ops_pkg::addr_t  out_addr,
    output alu_ops_pkg::data_t  out_data
);

    localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

    logic [CREDIT_W-1:0] credit_count;

    // A credit is spent in the out_valid cycle, so the packet already
    // registered for sending still holds one of the counted credits
    assign fifo_pop = ~fifo_empty & (credit_count > CREDIT_W'(out_valid));

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            credit_count <= CREDIT_W'(OUT_CREDITS);
            out_valid    <= 1'b0;
        end else begin
            credit_count <= credit_count - CREDIT_W'(out_valid) + CREDIT_W'(out_credit);
            out_valid    <= fifo_pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (fifo_pop) begin
            out_route_from <= fifo_route_from;
            out_route_to   <= fifo_route_to;
            out_addr       <= fifo_addr;
            out_data       <= fifo_data;
        end
    end

endmodule

/* logic/alu_ops_kernel.sv */
// One-stage ALU: on issue, registers the head packet with its data replaced by
// data OP operand. res_valid follows issue by one cycle.
`timescale 1ns/1ns

module alu_ops_kernel (
    input  logic                 ap_clk,
    input  logic                 areset_generator,
    input  logic                 issue,
    input  alu_ops_pkg::alu_op_t op,
    input  alu_ops_pkg::data_t   operand,
    input  alu_ops_pkg::route_t  in_route_from,
    input  alu_ops_pkg::route_t  in_route_to,
    input  alu_ops_pkg::addr_t   in_addr,
    input  alu_ops_pkg::data_t   in_data,
    output logic                 res_valid,
    output alu_ops_pkg::route_t  res_route_from,
    output alu_ops_pkg::route_t  res_route_to,
    output alu_ops_pkg::addr_t   res_addr,
    output alu_ops_pkg::data_t   res_data
);
    import alu_ops_pkg::*;

    data_t alu_result;

    // Add and subtract wrap at 32 bits
    always_comb begin
        case (op)
            ALU_ADD: alu_result = in_data + operand;
            ALU_SUB: alu_result = in_data - operand;
            ALU_AND: alu_result = in_data & operand;
            ALU_OR:  alu_result = in_data | operand;
            ALU_XOR: alu_result = in_data ^ operand;
            default: alu_result = in_data;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue;
        end
    end

    // Meta fields pass through unchanged
    always_ff @(posedge ap_clk) begin
        if (issue) begin
            res_route_from <= in_route_from;
            res_route_to   <= in_route_to;
            res_addr       <= in_addr;
            res_data       <= alu_result;
        end
    end

endmodule

/* logic/alu_ops_control.sv */
// Job controller: takes a descriptor and a configuration beat, then issues packets
// from the input FIFO into the kernel until the job count runs out.
`timescale 1ns/1ns

module alu_ops_control (
    input  logic                 ap_clk,
    input  logic                 areset_generator,
    input  logic                 descriptor_valid,
    input  alu_ops_pkg::count_t  descriptor_count,
    input  logic                 config_valid,
    input  alu_ops_pkg::alu_op_t config_op,
    input  alu_ops_pkg::data_t   config_operand,
    input  logic                 in_empty,
    input  logic                 out_almost_full,
    output logic                 issue,
    output alu_ops_pkg::alu_op_t op,
    output alu_ops_pkg::data_t   operand,
    output logic                 busy,
    output logic                 done
);
    import alu_ops_pkg::*;

    ctrl_state_t state;
    count_t      remaining;

    // ------------------------------------------------------------------
    // Issue gate
    // ------------------------------------------------------------------
    // Holds off while the output FIFO is near full, which covers the
    // one packet still in flight through the kernel
    assign issue = (state == CTRL_BUSY) & ~in_empty & ~out_almost_full &
                   (remaining != '0);

    // ------------------------------------------------------------------
    // Job state and remaining count
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state     <= CTRL_IDLE;
            remaining <= '0;
            op        <= ALU_PASS;
        end else begin
            case (state)
                CTRL_IDLE: begin
                    if (descriptor_valid) begin
                        remaining <= descriptor_count;
                        state     <= CTRL_CONFIG;
                    end
                end
                CTRL_CONFIG: begin
                    if (config_valid) begin
                        op <= config_op;
                        // Empty job finishes right after its configuration
                        state <= (remaining == '0) ? CTRL_DONE : CTRL_BUSY;
                    end
                end
                CTRL_BUSY: begin
                    if (issue) begin
                        remaining <= remaining - 1'b1;
                        if (remaining == count_t'(1)) begin
                            state <= CTRL_DONE;
                        end
                    end
                end
                CTRL_DONE: begin
                    state <= CTRL_IDLE;
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // Operand word for the whole job
    always_ff @(posedge ap_clk) begin
        if ((state == CTRL_CONFIG) && config_valid) begin
            operand <= config_operand;
        end
    end

    assign busy = (state == CTRL_CONFIG) | (state == CTRL_BUSY);
    assign done = (state == CTRL_DONE);

endmodule

/* logic/packet_fifo.sv */
// Synchronous show-ahead FIFO of packet fields; the head entry is always on rd_*.
// Used for both the input and the output side of the engine.
`timescale 1ns/1ns

module packet_fifo #(
    parameter int DEPTH              = alu_ops_pkg::DEFAULT_FIFO_DEPTH,
    parameter int ALMOST_FULL_MARGIN = 2
) (
    input  logic                ap_clk,
    input  logic                areset_generator,
    input  logic                wr_en,
    input  alu_ops_pkg::route_t wr_route_from,
    input  alu_ops_pkg::route_t wr_route_to,
    input  alu_ops_pkg::addr_t  wr_addr,
    input  alu_ops_pkg::data_t  wr_data,
    input  logic                rd_en,
    output alu_ops_pkg::route_t rd_route_from,
    output alu_ops_pkg::route_t rd_route_to,
    output alu_ops_pkg::addr_t  rd_addr,
    output alu_ops_pkg::data_t  rd_data,
    output logic                empty,
    output logic                full,
    output logic                almost_full
);
    import alu_ops_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    route_t mem_route_from [DEPTH];
    route_t mem_route_to   [DEPTH];
    addr_t  mem_addr       [DEPTH];
    data_t  mem_data       [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // Overflow and underflow requests are dropped
    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem_route_from[wr_ptr] <= wr_route_from;
            mem_route_to[wr_ptr]   <= wr_route_to;
            mem_addr[wr_ptr]       <= wr_addr;
            mem_data[wr_ptr]       <= wr_data;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head of queue
    assign rd_route_from = mem_route_from[rd_ptr];
    assign rd_route_to   = mem_route_to[rd_ptr];
    assign rd_addr       = mem_addr[rd_ptr];
    assign rd_data       = mem_data[rd_ptr];

    assign empty       = (count == '0);
    assign full        = (count == CNT_W'(DEPTH));
    assign almost_full = (count >= CNT_W'(DEPTH - ALMOST_FULL_MARGIN));

endmodule

/* logic/alu_ops_pkg.sv */
// Shared types, operation codes and defaults for the ALU-operation stage.
// Imported by every module of the engine.
package alu_ops_pkg;

    // ------------------------------------------------------------------
    // Packet fields
    // ------------------------------------------------------------------
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  route_t;

    // Job packet count, also the width of the remaining counter
    typedef logic [15:0] count_t;

    // ------------------------------------------------------------------
    // Operation codes
    // ------------------------------------------------------------------
    // Codes above ALU_XOR fall back to PASS in the kernel
    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5
    } alu_op_t;

    // ------------------------------------------------------------------
    // Controller states
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        CTRL_IDLE   = 2'd0,
        CTRL_CONFIG = 2'd1,
        CTRL_BUSY   = 2'd2,
        CTRL_DONE   = 2'd3
    } ctrl_state_t;

    // Defaults for the top-level parameters
    localparam int DEFAULT_FIFO_DEPTH  = 16;
    localparam int DEFAULT_OUT_CREDITS = 4;

endpackage
